/* source/ir_sense_pkg.sv */
/*
 * Sensor-side definitions for a fixed six-channel IR bar.
 * Channel codes are the A2D mux inputs. Sweep order and group mapping are hard-wired.
 */
package ir_sense_pkg;

    localparam int A2D_W = 12;

    localparam logic [12:0] SETTLE_LONG   = 13'd4096; // first channel of a pair
    localparam logic [12:0] SETTLE_SHORT  = 13'd32;
    localparam logic [7:0]  PWM_OFF_COUNT = 8'h8C;

    localparam logic [2:0] W_IN  = 3'd1;
    localparam logic [2:0] W_MID = 3'd2;
    localparam logic [2:0] W_OUT = 3'd4;

    typedef enum logic [2:0] {
        chan_0 = 3'd0,
        chan_1 = 3'd1,
        chan_2 = 3'd2,
        chan_3 = 3'd3,
        chan_4 = 3'd4,
        chan_7 = 3'd7
    } ir_chan_e;

    typedef enum logic [1:0] {grp_in, grp_mid, grp_out} ir_group_e;

    typedef enum logic [2:0] {idle, settle, conv_dummy, conv_real, sample_out} seq_state_e;

    typedef struct packed {
        ir_chan_e           channel;
        logic [A2D_W-1:0]   value;
    } ir_sample_t;

    // sweep order 1, 0, 4, 2, 3, 7
    function automatic ir_chan_e next_chan(input ir_chan_e ch);
        case (ch)
            chan_1:  return chan_0;
            chan_0:  return chan_4;
            chan_4:  return chan_2;
            chan_2:  return chan_3;
            chan_3:  return chan_7;
            default: return chan_1;
        endcase
    endfunction

    // 1, 4 and 3 lead their pair; long settle, positive side of the error
    function automatic logic is_first_of_pair(input ir_chan_e ch);
        return (ch == chan_1) || (ch == chan_4) || (ch == chan_3);
    endfunction

    function automatic ir_group_e chan_group(input ir_chan_e ch);
        case (ch)
            chan_1, chan_0: return grp_in;
            chan_4, chan_2: return grp_mid;
            default:        return grp_out;
        endcase
    endfunction

    function automatic logic [2:0] chan_weight(input ir_chan_e ch);
        case (chan_group(ch))
            grp_in:  return W_IN;
            grp_mid: return W_MID;
            default: return W_OUT;
        endcase
    endfunction

endpackage

/* source/pi_ctrl_pkg.sv */
/*
 * Control-side types and constants. Gains are unsigned magnitudes applied to
 * signed operands. Every product is arithmetically shifted right by GAIN_SHIFT.
 */
package pi_ctrl_pkg;

    typedef logic signed [11:0] error_t;
    typedef logic signed [11:0] motor_t;

    localparam logic [13:0] P_TERM     = 14'h3680;
    localparam logic [11:0] I_TERM     = 12'h500;
    localparam int          GAIN_SHIFT = 12;
    localparam int          INT_SHIFT  = 4;

    localparam int INT_DECIMATE = 4;    // integrate once per 4 sweeps
    localparam int DEC_W        = $clog2(INT_DECIMATE);

    localparam logic [11:0] FWD_CAP = 12'h700;

    typedef enum logic [1:0] {pi_idle, pi_intgrl, pi_gain, pi_motor} pi_state_e;

    typedef struct packed {
        error_t error;
        logic   valid;
    } err_result_t;

    // clamp to the 12 bit signed range
    function automatic error_t sat_12(input logic signed [15:0] v);
        if (v > 16'sd2047) begin
            return 12'sh7FF;
        end else if (v < -16'sd2048) begin
            return 12'sh800;
        end
        return v[11:0];
    endfunction

endpackage

/* source/ir_sequencer.sv */
/*
 * Each strt_cnv must be answered by exactly one cnv_cmplt, at least one cycle later.
 * The first conversion of every channel is thrown away. A sweep starts only from idle
 * with go high and always finishes once started.
 */
`timescale 1ns/1ps

module ir_sequencer import ir_sense_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             go,
    input  logic             cnv_cmplt,
    input  logic [A2D_W-1:0] A2D_res,
    output logic             strt_cnv,
    output ir_chan_e         chnnl,
    output logic             ir_on,
    output logic             pwm_start,
    output ir_sample_t       sample,
    output logic             sample_valid
);

    seq_state_e  state;
    logic [12:0] timer;         // settle counter
    logic [12:0] settle_len;

    // long settle when the IR group has just been switched
    assign settle_len = is_first_of_pair(chnnl) ? SETTLE_LONG : SETTLE_SHORT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= idle;
            timer        <= '0;
            chnnl        <= chan_1;
            strt_cnv     <= 1'b0;
            ir_on        <= 1'b0;
            pwm_start    <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            strt_cnv     <= 1'b0;
            pwm_start    <= 1'b0;
            sample_valid <= 1'b0;
            case (state)
                idle: begin
                    if (go) begin
                        state     <= settle;
                        timer     <= '0;
                        ir_on     <= 1'b1;
                        pwm_start <= 1'b1;
                    end
                end
                settle: begin
                    if (timer == settle_len - 13'd1) begin
                        state    <= conv_dummy;
                        strt_cnv <= 1'b1;
                    end else begin
                        timer <= timer + 13'd1;
                    end
                end
                conv_dummy: begin
                    if (cnv_cmplt) begin  // result discarded
                        state    <= conv_real;
                        strt_cnv <= 1'b1;
                    end
                end
                conv_real: begin
                    if (cnv_cmplt) begin
                        state        <= sample_out;
                        sample_valid <= 1'b1;
                        ir_on        <= 1'b0;
                    end
                end
                sample_out: begin
                    chnnl <= next_chan(chnnl);
                    if (chnnl == chan_7) begin
                        state <= idle;  // wraps to channel 1
                    end else begin
                        state     <= settle;
                        timer     <= '0;
                        ir_on     <= 1'b1;
                        pwm_start <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // real conversion result, tagged with its channel
    always_ff @(posedge clk) begin
        if (state == conv_real && cnv_cmplt) begin
            sample.channel <= chnnl;
            sample.value   <= A2D_res;
        end
    end

    // the converter sees a clean edge for every request
    a_strt_cnv_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) strt_cnv |=> !strt_cnv
    ) else $error("strt_cnv held high for two cycles");

endmodule

/* source/ir_pwm.sv */
/*
 * IR emitter drive. The pulse is only meaningful while ir_on is high.
 * Only the group of the current channel is lit.
 * chnnl may only change along with pwm_start.
 */
`timescale 1ns/1ps

module ir_pwm import ir_sense_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  ir_chan_e chnnl,
    input  logic     ir_on,
    input  logic     pwm_start,
    output logic     IR_in_en,
    output logic     IR_mid_en,
    output logic     IR_out_en
);

    logic [7:0] pwm_cnt;
    logic       pulse;
    logic       lit;
    ir_group_e  group;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
        end else if (!ir_on || pwm_start) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 8'd1;  // wraps every 256
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pulse <= 1'b0;
        end else if (pwm_start) begin
            pulse <= 1'b1;
        end else if (!ir_on) begin
            pulse <= 1'b0;
        end else if (pwm_cnt == 8'hFF) begin
            pulse <= 1'b1;
        end else if (pwm_cnt == PWM_OFF_COUNT) begin
            pulse <= 1'b0;
        end
    end

    assign group = chan_group(chnnl);
    assign lit   = pulse && ir_on;  // drops with ir_on, no trailing cycle

    assign IR_in_en  = lit && (group == grp_in);
    assign IR_mid_en = lit && (group == grp_mid);
    assign IR_out_en = lit && (group == grp_out);

    // group routing must not switch under a running pulse
    a_chan_stable: assert property (
        @(posedge clk) disable iff (!rst_n) (ir_on && !pwm_start) |-> $stable(chnnl)
    ) else $error("channel changed while its IR group was on");

endmodule

/* source/error_accum.sv */
/*
 * Samples must arrive in sweep order, starting with channel 1.
 * Error = in*1 + mid*2 + out*4 over the pair differences, saturated to 12 bits.
 */
`timescale 1ns/1ps

module error_accum import ir_sense_pkg::*, pi_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  ir_sample_t  sample,
    input  logic        sample_valid,
    output err_result_t err,
    output logic [7:0]  LEDs
);

    logic signed [15:0] accum;
    logic        [15:0] mag;
    logic signed [15:0] base;
    logic signed [15:0] sum;

    // at most 4095 * 4, no overflow in 16 bits
    assign mag  = 16'(sample.value) * 16'(chan_weight(sample.channel));
    assign base = (sample.channel == chan_1) ? 16'sd0 : accum;  // new sweep
    assign sum  = is_first_of_pair(sample.channel) ? base + $signed(mag)
                                                   : base - $signed(mag);

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            accum <= sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err  <= '0;
            LEDs <= '0;
        end else begin
            err.valid <= 1'b0;
            if (sample_valid && sample.channel == chan_7) begin
                err.error <= sat_12(sum);
                err.valid <= 1'b1;
            end
            if (err.valid) begin
                LEDs <= err.error[11:4];    // top 8 bits of the error
            end
        end
    end

endmodule

/* source/pi_controller.sv */
/*
 * Four cycles per error: integrate, gains, motors, back to idle.
 * A new error must not arrive while a computation is running.
 * The forward speed used by a sweep is the value before that sweep's ramp step.
 */
`timescale 1ns/1ps

module pi_controller import pi_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        go,
    input  err_result_t err,
    output motor_t      lft_motor,
    output motor_t      rht_motor
);

    pi_state_e          state;
    logic [DEC_W-1:0]   dec_cnt;    // sweeps since reset, mod INT_DECIMATE
    error_t             err_q;
    error_t             intgrl;
    logic [11:0]        fwd;
    logic [11:0]        fwd_snap;
    logic signed [15:0] pcomp;
    logic signed [15:0] icomp;
    logic signed [15:0] int_sum;
    logic signed [15:0] rht_sum;
    logic signed [15:0] lft_sum;
    logic signed [26:0] p_prod;
    logic signed [26:0] i_prod;

    assign int_sum = 16'(intgrl) + 16'(err_q >>> INT_SHIFT);
    assign p_prod  = 27'(err_q) * 27'($signed({1'b0, P_TERM}));
    assign i_prod  = 27'(intgrl) * 27'($signed({1'b0, I_TERM}));
    assign rht_sum = $signed({4'b0000, fwd_snap}) - pcomp - icomp;
    assign lft_sum = $signed({4'b0000, fwd_snap}) + pcomp + icomp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= pi_idle;
            dec_cnt   <= '0;
            intgrl    <= '0;
            fwd       <= '0;
            lft_motor <= '0;
            rht_motor <= '0;
        end else begin
            case (state)
                pi_idle: begin
                    if (err.valid) begin
                        state <= pi_intgrl;
                    end
                end
                pi_intgrl: begin
                    dec_cnt <= dec_cnt + 1'b1;
                    if (dec_cnt == DEC_W'(INT_DECIMATE - 1)) begin
                        intgrl <= sat_12(int_sum);
                    end
                    state <= pi_gain;
                end
                pi_gain: state <= pi_motor;
                pi_motor: begin
                    rht_motor <= sat_12(rht_sum);
                    lft_motor <= sat_12(lft_sum);
                    state     <= pi_idle;
                end
                default: state <= pi_idle;
            endcase

            if (!go) begin
                fwd <= '0;
            end else if (state == pi_intgrl && fwd < FWD_CAP) begin
                fwd <= fwd + 12'd1;     // one step per sweep
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == pi_idle && err.valid) begin
            err_q    <= err.error;
            fwd_snap <= fwd;
        end
        if (state == pi_gain) begin
            pcomp <= 16'(p_prod >>> GAIN_SHIFT);
            icomp <= 16'(i_prod >>> GAIN_SHIFT);    // uses this sweep's integrator
        end
    end

    // next sweep's error must not land in the middle of a computation
    a_err_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) err.valid |-> state == pi_idle
    ) else $error("error arrived while PI busy");

endmodule

/* source/motion_cntrl.sv */
/*
 * Line follower motion controller. Motor outputs are the top 11 bits of
 * the 12 bit signed motor values.
 */
`timescale 1ns/1ps

module motion_cntrl import ir_sense_pkg::*, pi_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        go,
    output logic        strt_cnv,
    output logic [2:0]  chnnl,
    input  logic        cnv_cmplt,
    input  logic [11:0] A2D_res,
    output logic        IR_in_en,
    output logic        IR_mid_en,
    output logic        IR_out_en,
    output logic [7:0]  LEDs,
    output logic [10:0] lft,
    output logic [10:0] rht
);

    ir_chan_e    chnnl_w;
    logic        ir_on;
    logic        pwm_start;
    ir_sample_t  sample;
    logic        sample_valid;
    err_result_t err;
    motor_t      lft_motor;
    motor_t      rht_motor;

    assign chnnl = chnnl_w;
    assign lft   = lft_motor[11:1];
    assign rht   = rht_motor[11:1];

    ir_sequencer u_seq (
        .clk, .rst_n, .go, .cnv_cmplt, .A2D_res, .strt_cnv,
        .chnnl(chnnl_w), .ir_on, .pwm_start, .sample, .sample_valid
    );

    ir_pwm u_pwm (
        .clk, .rst_n, .chnnl(chnnl_w), .ir_on, .pwm_start,
        .IR_in_en, .IR_mid_en, .IR_out_en
    );

    error_accum u_err (.clk, .rst_n, .sample, .sample_valid, .err, .LEDs);

    pi_controller u_pi (.clk, .rst_n, .go, .err, .lft_motor, .rht_motor);

endmodule

/* testbench/tb_motion_model.svh */
/*
 * Reference model for the motion controller testbench, in plain ints.
 * Sample positions follow the sweep order 1, 0, 4, 2, 3, 7.
 */
`ifndef TB_MOTION_MODEL_SVH
`define TB_MOTION_MODEL_SVH

// 12 bit signed range
function automatic int clamp12(input int v);
    if (v > 2047) begin
        return 2047;
    end
    if (v < -2048) begin
        return -2048;
    end
    return v;
endfunction

// even positions add, odd subtract; pairs weigh 1, 2, 4
function automatic int steer_error(input int vals[6]);
    int sum;
    sum = 0;
    for (int i = 0; i < 6; i++) begin
        if (i % 2 == 0) begin
            sum = sum + (vals[i] << (i / 2));
        end else begin
            sum = sum - (vals[i] << (i / 2));
        end
    end
    return clamp12(sum);
endfunction

function automatic int integrate(input int intgrl, input int err);
    return clamp12(intgrl + (err >>> INT_SHIFT));
endfunction

function automatic void motor_values(input int err, input int intgrl, input int fwd,
                                     output int lft, output int rht);
    int pcomp;
    int icomp;
    pcomp = (err * int'(P_TERM)) >>> GAIN_SHIFT;
    icomp = (intgrl * int'(I_TERM)) >>> GAIN_SHIFT;
    lft   = clamp12(fwd + pcomp + icomp);
    rht   = clamp12(fwd - pcomp - icomp);
endfunction

function automatic int ramp_fwd(input int fwd);
    return (fwd < int'(FWD_CAP)) ? fwd + 1 : fwd;
endfunction

// motor pins carry bits 11 down to 1
function automatic logic [10:0] motor_pins(input int m);
    return 11'(m >>> 1);
endfunction

function automatic logic [7:0] led_bits(input int err);
    return 8'(err >>> 4);
endfunction

`endif

/* testbench/tb_motion_cntrl.sv */
/*
 * Testbench for motion_cntrl. The A2D responder answers every strt_cnv after 2 to 20 cycles.
 * go stays high for five sweeps, drops for an idle gap, then allows one more sweep.
 */
`timescale 1ns/1ps

module tb_motion_cntrl import pi_ctrl_pkg::*; ();

    localparam int RAND_SEED   = 85832;
    localparam int CYCLE_LIMIT = 100000;   // 6 sweeps of ~12700 cycles, two idle gaps, margin
    localparam int IDLE_GAP    = 5000;     // longer than a long settle
    localparam logic [2:0] SWEEP_ORDER [6] = '{3'd1, 3'd0, 3'd4, 3'd2, 3'd3, 3'd7};

    logic        clk = 1'b0;
    logic        rst_n;
    logic        go;
    logic        strt_cnv;
    logic [2:0]  chnnl;
    logic        cnv_cmplt = 1'b0;
    logic [11:0] A2D_res = 12'h000;
    logic        IR_in_en;
    logic        IR_mid_en;
    logic        IR_out_en;
    logic [7:0]  LEDs;
    logic [10:0] lft;
    logic [10:0] rht;

    int          n_errors = 0;
    int          n_checks = 0;
    int          cycles = 0;
    int          conv_cnt = 0;      // strt_cnv pulses seen
    int          chan_idx = 0;      // position in the sweep order
    int          resp_wait = 0;
    int          sweep_num = 0;
    int          sweeps_done = 0;
    int          led_cd = 0;
    int          mot_cd = 0;
    int          real_vals [6];
    int          intgrl_m = 0;
    int          fwd_m = 0;
    int          err_m = 0;
    logic        real_pending = 1'b0;
    logic        idle_watch = 1'b0;
    logic [2:0]  en_seen = 3'b000;
    logic [7:0]  exp_leds;
    logic [10:0] exp_lft;
    logic [10:0] exp_rht;

    `include "tb_motion_model.svh"

    motion_cntrl UUT (
        .clk, .rst_n, .go, .strt_cnv, .chnnl, .cnv_cmplt, .A2D_res,
        .IR_in_en, .IR_mid_en, .IR_out_en, .LEDs, .lft, .rht
    );

    always #10 clk = ~clk;

    task automatic compare_value(input string name, input int expected, input int actual);
        n_checks++;
        if (actual != expected) begin
            n_errors++;
            $display("ERR %s expected %0h actual %0h at %0t", name, expected, actual, $time);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // A2D responder, sweep tracking and the timed output checks
    always @(negedge clk) begin
        logic [2:0] en;
        int         lft_m;
        int         rht_m;
        en = {IR_out_en, IR_mid_en, IR_in_en};
        if (rst_n) begin
            cnv_cmplt = 1'b0;
            if ((en & ~(3'b001 << (chan_idx / 2))) != 3'b000) begin
                n_errors++;
                $display("wrong IR group lit on channel %0d, enables %b at %0t",
                         SWEEP_ORDER[chan_idx], en, $time);
            end
            en_seen = en_seen | en;
            if (idle_watch && (en != 3'b000 || strt_cnv)) begin
                n_errors++;
                $display("conversion or IR enable while idle with go low at %0t", $time);
            end
            if (led_cd > 0) begin
                led_cd--;
                if (led_cd == 0) begin
                    compare_value("leds", exp_leds, LEDs);
                end
            end
            if (mot_cd > 0) begin
                mot_cd--;
                if (mot_cd == 0) begin
                    compare_value("motor_lft", exp_lft, lft);
                    compare_value("motor_rht", exp_rht, rht);
                    sweeps_done++;
                end
            end
            if (resp_wait > 0) begin
                resp_wait--;
                if (resp_wait == 0) begin
                    cnv_cmplt = 1'b1;
                    A2D_res   = 12'($urandom);
                    if (real_pending) begin
                        real_vals[chan_idx] = int'(A2D_res);
                        if (chan_idx == 5) begin     // last channel, predict this sweep
                            sweep_num++;
                            err_m = steer_error(real_vals);
                            if (sweep_num % INT_DECIMATE == 0) begin
                                intgrl_m = integrate(intgrl_m, err_m);
                            end
                            if (!go) begin
                                fwd_m = 0;
                            end
                            motor_values(err_m, intgrl_m, fwd_m, lft_m, rht_m);
                            if (go) begin
                                fwd_m = ramp_fwd(fwd_m);
                            end
                            exp_leds = led_bits(err_m);
                            exp_lft  = motor_pins(lft_m);
                            exp_rht  = motor_pins(rht_m);
                            led_cd   = 3;
                            mot_cd   = 6;
                        end
                        chan_idx = (chan_idx + 1) % 6;
                    end
                end
            end
            if (strt_cnv) begin
                if (resp_wait > 0) begin
                    n_errors++;
                    $display("strt_cnv while a conversion was still running at %0t", $time);
                end
                compare_value("sweep_order", SWEEP_ORDER[chan_idx], chnnl);
                real_pending = (conv_cnt % 2 == 1);  // second of the pair
                conv_cnt++;
                resp_wait = 2 + int'($urandom % 19);
            end
        end
    end

    initial begin
        int seed_ret;
        rst_n    = 1'b0;
        go       = 1'b0;
        seed_ret = $urandom(RAND_SEED);
        repeat (4) @(negedge clk);
        compare_value("reset_leds", 0, LEDs);
        compare_value("reset_lft", 0, lft);
        compare_value("reset_rht", 0, rht);
        compare_value("reset_chnnl", 1, chnnl);
        rst_n = 1'b1;
        go    = 1'b1;

        wait (conv_cnt == 59);      // channel 7 of the fifth sweep
        @(negedge clk);
        go = 1'b0;
        wait (sweeps_done == 5);
        @(negedge clk);
        idle_watch = 1'b1;
        repeat (IDLE_GAP) @(negedge clk);
        idle_watch = 1'b0;
        compare_value("idle_conversions", 60, conv_cnt);

        go = 1'b1;
        wait (conv_cnt == 71);
        @(negedge clk);
        go = 1'b0;
        wait (sweeps_done == 6);
        @(negedge clk);
        idle_watch = 1'b1;
        repeat (IDLE_GAP) @(negedge clk);
        compare_value("final_conversions", 72, conv_cnt);
        compare_value("groups_lit", 3'b111, en_seen);

        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* motion_cntrl.f */
+incdir+testbench
source/ir_sense_pkg.sv
source/pi_ctrl_pkg.sv
source/ir_sequencer.sv
source/ir_pwm.sv
source/error_accum.sv
source/pi_controller.sv
source/motion_cntrl.sv
testbench/tb_motion_cntrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the motion controller testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_motion_cntrl \
    -f motion_cntrl.f --Mdir obj_dir -o sim_motion_cntrl \
    && ./obj_dir/sim_motion_cntrl > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

[ -f sim.log ] && cat sim.log

grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
